// ==== build.f ====
+incdir+include
logic/rvv_cmd_pkg.sv
logic/rvv_data_pkg.sv
logic/multi_fifo.sv
logic/rvv_decode.sv
logic/rvv_valu.sv
logic/rvv_vrf.sv
logic/rvv_backend.sv
test/tb_rvv_backend.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector back end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module tb_rvv_backend -Mdir obj_dir

obj_dir/Vtb_rvv_backend | tee sim.log

if grep -qx "Test passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== test/tb_rvv_backend.sv ====
`timescale 1ns/1ps
`include "rvv_settings.svh"

module tb_rvv_backend;
    import rvv_cmd_pkg::*;
    import rvv_data_pkg::*;

    localparam int NUM_CMDS   = 300;
    localparam int MAX_CYCLES = NUM_CMDS * 15 + 500;

    logic                               clk;
    logic                               rst_n;
    logic [`ISSUE_LANE-1:0]             insts_valid;
    rvv_cmd_t [`ISSUE_LANE-1:0]         insts;
    logic [`ISSUE_LANE-1:0]             insts_ready;
    logic                               rt_valid;
    rt_rec_t                            rt_rec;
    logic                               trap_valid;
    logic                               trap_ready;

    vreg_t                  shadow [`NUM_VREG];
    rvv_cmd_t               pending [$];
    rvv_cmd_t               offer [$];
    logic [31:0]            rng;
    logic [31:0]            next_pc;
    int                     issued;
    int                     accepted_cnt;
    int                     acc_total;
    int                     retired;
    int                     errors;
    int                     cycles;
    logic                   trap_seen;
    logic                   exp_have;
    logic [31:0]            exp_pc;
    logic [`VREG_IDX_W-1:0] exp_vd;
    logic                   exp_illegal;
    vreg_t                  exp_data;

    rvv_backend UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .insts_valid (insts_valid),
        .insts       (insts),
        .insts_ready (insts_ready),
        .rt_valid    (rt_valid),
        .rt_rec      (rt_rec),
        .trap_valid  (trap_valid),
        .trap_ready  (trap_ready)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    // OPIVV encoding, registers limited to v0..v15 so results get reused
    function automatic rvv_cmd_t make_cmd(logic [31:0] pc, logic [31:0] r);
        rvv_cmd_t   c;
        logic [5:0] f6;
        case (r[2:0])
            3'd0, 3'd5: f6 = 6'b000000;
            3'd1, 3'd6: f6 = 6'b000010;
            3'd2, 3'd7: f6 = 6'b001001;
            3'd3:       f6 = 6'b001010;
            default:    f6 = 6'b001011;
        endcase
        // Roughly one in sixteen gets a funct6 outside the ALU set
        if (r[31:28] == 4'h0) begin
            f6 = 6'b100101;
        end
        c.pc   = pc;
        c.inst = {f6, 1'b1, 1'b0, r[13:10], 1'b0, r[9:6], 3'b000, 1'b0, r[17:14], 7'b1010111};
        case (r[5:4])
            2'd1:    c.sew = SEW16;
            2'd2:    c.sew = SEW32;
            default: c.sew = SEW8;
        endcase
        return c;
    endfunction

    function automatic logic cmd_illegal(rvv_cmd_t c);
        logic [5:0] f6;
        f6 = c.inst[31:26];
        if (c.inst[6:0] != 7'b1010111 || c.inst[14:12] != 3'b000) begin
            return 1'b1;
        end
        return !(f6 inside {6'b000000, 6'b000010, 6'b001001, 6'b001010, 6'b001011});
    endfunction

    // vd = vs2 op vs1, element by element at the command's SEW
    function automatic vreg_t expect_result(rvv_cmd_t c, vreg_t vs2_val, vreg_t vs1_val);
        int          w;
        vreg_t       res;
        logic [31:0] mask;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        w    = (c.sew == SEW8) ? 8 : ((c.sew == SEW16) ? 16 : 32);
        mask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
        res  = '0;
        for (int i = 0; i < `VLEN / w; i++) begin
            x = 32'(vs2_val >> (i * w)) & mask;
            y = 32'(vs1_val >> (i * w)) & mask;
            case (c.inst[31:26])
                6'b000000: z = x + y;
                6'b000010: z = x - y;
                6'b001001: z = x & y;
                6'b001010: z = x | y;
                default:   z = x ^ y;
            endcase
            res = res | (vreg_t'(z & mask) << (i * w));
        end
        return res;
    endfunction

    task automatic load_reset_pattern();
        for (int r = 0; r < `NUM_VREG; r++) begin
            for (int b = 0; b < `VLEN / 8; b++) begin
                shadow[r][b*8 +: 8] = 8'(r * 16 + b);
            end
        end
    endtask

    // Drops what the last edge took, tops up to want lanes, holds the rest
    task automatic drive_lanes(input int want);
        for (int k = 0; k < accepted_cnt; k++) begin
            void'(offer.pop_front());
        end
        while (offer.size() < want && issued < NUM_CMDS) begin
            offer.push_back(make_cmd(next_pc, rand_word()));
            next_pc = next_pc + 32'd4;
            issued++;
        end
        for (int l = 0; l < `ISSUE_LANE; l++) begin
            if (l < offer.size()) begin
                insts_valid[l] <= 1'b1;
                insts[l]       <= offer[l];
            end else begin
                insts_valid[l] <= 1'b0;
                insts[l]       <= '0;
            end
        end
    endtask

    task automatic report_counts();
        $display("Checks done: %0d errors, %0d commands accepted, %0d retired",
            errors, acc_total, retired);
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        rvv_cmd_t head;
        if (rst_n) begin
            if (rt_valid) begin
                retired++;
                exp_have = (pending.size() > 0);
                if (exp_have) begin
                    head        = pending.pop_front();
                    exp_pc      = head.pc;
                    exp_vd      = head.inst[11:7];
                    exp_illegal = cmd_illegal(head);
                    exp_data    = expect_result(head, shadow[head.inst[24:20]],
                        shadow[head.inst[19:15]]);
                    if (!exp_illegal) begin
                        shadow[exp_vd] = exp_data;
                    end
                end
            end
            // Queues clear at the end of the trap cycle
            if (trap_ready) begin
                trap_seen = 1'b1;
                pending.delete();
            end
            accepted_cnt = 0;
            for (int l = 0; l < `ISSUE_LANE; l++) begin
                if (insts_valid[l] && insts_ready[l]) begin
                    pending.push_back(insts[l]);
                    accepted_cnt++;
                    acc_total++;
                end
            end
        end
    end

    always @(negedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped at the cycle limit with %0d commands not retired",
                pending.size() + offer.size());
            report_counts();
            $display("Test failed");
            $finish;
        end
    end

    a_reset_rt: assert property (@(posedge clk) $rose(rst_n) |-> !rt_valid)
    else begin
        errors++;
        $display("error rt_valid after reset: got %h expected 0", $sampled(rt_valid));
    end

    a_reset_trap: assert property (@(posedge clk) $rose(rst_n) |-> !trap_ready)
    else begin
        errors++;
        $display("error trap_ready after reset: got %h expected 0", $sampled(trap_ready));
    end

    a_reset_ready: assert property (@(posedge clk) $rose(rst_n) |-> insts_ready == 2'b11)
    else begin
        errors++;
        $display("error insts_ready after reset: got %h expected 3", $sampled(insts_ready));
    end

    a_lane_order: assert property (@(posedge clk) disable iff (!rst_n)
        insts_ready[1] |-> insts_ready[0])
    else begin
        errors++;
        $display("error insts_ready: got %h with lane 1 ready and lane 0 not",
            $sampled(insts_ready));
    end

    a_rt_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid |-> exp_have)
    else begin
        errors++;
        $display("Retirement seen with no accepted command outstanding");
    end

    a_rt_pc: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid && exp_have |-> rt_rec.pc == exp_pc)
    else begin
        errors++;
        $display("error rt_rec.pc: got %h expected %h", $sampled(rt_rec.pc), exp_pc);
    end

    a_rt_vd: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid && exp_have |-> rt_rec.vd == exp_vd)
    else begin
        errors++;
        $display("error rt_rec.vd: got %h expected %h", $sampled(rt_rec.vd), exp_vd);
    end

    a_rt_illegal: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid && exp_have |-> rt_rec.illegal == exp_illegal)
    else begin
        errors++;
        $display("error rt_rec.illegal: got %h expected %h", $sampled(rt_rec.illegal),
            exp_illegal);
    end

    a_rt_data: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid && exp_have && !exp_illegal |-> rt_rec.data == exp_data)
    else begin
        errors++;
        $display("error rt_rec.data: got %h expected %h", $sampled(rt_rec.data), exp_data);
    end

    a_trap_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(trap_valid) |=> trap_ready)
    else begin
        errors++;
        $display("Trap request was not acknowledged on the following cycle");
    end

    a_trap_single: assert property (@(posedge clk) disable iff (!rst_n)
        trap_ready |=> !trap_ready)
    else begin
        errors++;
        $display("Trap acknowledge stayed high for more than one cycle");
    end

    a_trap_no_intake: assert property (@(posedge clk) disable iff (!rst_n)
        trap_ready |-> insts_ready == '0)
    else begin
        errors++;
        $display("error insts_ready during trap: got %h expected 0", $sampled(insts_ready));
    end

    initial begin
        rng          = 32'hc54e;
        next_pc      = 32'h0000_1000;
        issued       = 0;
        accepted_cnt = 0;
        acc_total    = 0;
        retired      = 0;
        errors       = 0;
        cycles       = 0;
        trap_seen    = 1'b0;
        exp_have     = 1'b0;
        exp_pc       = '0;
        exp_vd       = '0;
        exp_illegal  = 1'b0;
        exp_data     = '0;
        rst_n        = 1'b0;
        insts_valid  = '0;
        insts        = '0;
        trap_valid   = 1'b0;
        load_reset_pattern();

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Back-to-back pairs fill both queues
        while (issued < 120) begin
            @(posedge clk);
            drive_lanes(2);
        end

        // Trap with full queues, request dropped once the pulse is seen
        trap_valid <= 1'b1;
        do begin
            @(posedge clk);
            drive_lanes(2);
        end while (!trap_seen);
        trap_valid <= 1'b0;

        while (issued < NUM_CMDS || offer.size() > 0) begin
            @(posedge clk);
            drive_lanes(int'(rand_word() % 32'd3));
        end

        while (pending.size() > 0) begin
            @(posedge clk);
            drive_lanes(0);
        end
        repeat (2) @(posedge clk);

        report_counts();
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== logic/rvv_backend.sv ====
`timescale 1ns/1ps
`include "rvv_settings.svh"

module rvv_backend (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                  [`ISSUE_LANE-1:0] insts_valid,
    input  rvv_cmd_pkg::rvv_cmd_t [`ISSUE_LANE-1:0] insts,
    output logic                  [`ISSUE_LANE-1:0] insts_ready,
    output logic                                    rt_valid,
    output rvv_data_pkg::rt_rec_t                   rt_rec,
    input  logic                                    trap_valid,
    output logic                                    trap_ready
);
    import rvv_cmd_pkg::*;
    import rvv_data_pkg::*;

    logic                   is_trapping;
    logic [`ISSUE_LANE-1:0] cq_push;
    logic                   cq_full;
    logic                   cq_almost_full;
    logic                   cq_empty;
    logic                   cq_pop;
    rvv_cmd_t               cq_head;
    logic                   uq_push;
    logic                   uq_full;
    logic                   uq_empty;
    logic                   uq_pop;
    uop_t                   dec_uop;
    uop_t                   uq_head;
    logic [`VREG_IDX_W-1:0] rd_idx1;
    logic [`VREG_IDX_W-1:0] rd_idx2;
    vreg_t                  rd_data1;
    vreg_t                  rd_data2;
    logic                   wr_valid;
    logic [`VREG_IDX_W-1:0] wr_idx;
    vreg_t                  wr_data;

    // Lane 1 needs two free slots, intake closed during a trap
    assign insts_ready[0] = !is_trapping && !cq_full;
    assign insts_ready[1] = !is_trapping && !cq_almost_full;
    assign cq_push        = insts_valid & insts_ready;

    multi_fifo #(
        .T     (rvv_cmd_t),
        .M     (`ISSUE_LANE),
        .N     (1),
        .DEPTH (`CQ_DEPTH)
    ) u_cmd_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .push         (cq_push),
        .datain       (insts),
        .pop          (cq_pop),
        .dataout      (cq_head),
        .full         (cq_full),
        .almost_full  (cq_almost_full),
        .empty        (cq_empty),
        .almost_empty (),
        .clear        (is_trapping)
    );

    rvv_decode u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cq_head),
        .cq_empty (cq_empty),
        .cq_pop   (cq_pop),
        .uq_full  (uq_full),
        .uq_push  (uq_push),
        .uop      (dec_uop)
    );

    multi_fifo #(
        .T     (uop_t),
        .M     (1),
        .N     (1),
        .DEPTH (`UQ_DEPTH)
    ) u_uop_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .push         (uq_push),
        .datain       (dec_uop),
        .pop          (uq_pop),
        .dataout      (uq_head),
        .full         (uq_full),
        .almost_full  (),
        .empty        (uq_empty),
        .almost_empty (),
        .clear        (is_trapping)
    );

    rvv_valu u_valu (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (is_trapping),
        .uq_empty (uq_empty),
        .uq_pop   (uq_pop),
        .uop      (uq_head),
        .rd_idx1  (rd_idx1),
        .rd_idx2  (rd_idx2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr_valid (wr_valid),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .rt_valid (rt_valid),
        .rt_rec   (rt_rec)
    );

    rvv_vrf u_vrf (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_idx1  (rd_idx1),
        .rd_idx2  (rd_idx2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr_valid (wr_valid),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data)
    );

    // One-cycle trap window, queues flush at its closing edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            is_trapping <= 1'b0;
        end else begin
            is_trapping <= trap_valid && !is_trapping;
        end
    end

    assign trap_ready = is_trapping;

    // Nothing from before the trap survives its closing edge
    a_trap_flush: assert property (
        @(posedge clk) disable iff (!rst_n) trap_ready |=> cq_empty && uq_empty && !rt_valid
    ) else $error("rvv_backend: queues or ALU not flushed by trap");

endmodule

// ==== logic/rvv_vrf.sv ====
`timescale 1ns/1ps
`include "rvv_settings.svh"

module rvv_vrf (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`VREG_IDX_W-1:0] rd_idx1,
    input  logic [`VREG_IDX_W-1:0] rd_idx2,
    output rvv_data_pkg::vreg_t    rd_data1,
    output rvv_data_pkg::vreg_t    rd_data2,
    input  logic                   wr_valid,
    input  logic [`VREG_IDX_W-1:0] wr_idx,
    input  rvv_data_pkg::vreg_t    wr_data
);
    import rvv_data_pkg::*;

    vreg_t regs [`NUM_VREG];

    // Byte b of register r starts as r*16+b
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `NUM_VREG; r++) begin
                for (int b = 0; b < `VLEN / 8; b++) begin
                    regs[r][b*8 +: 8] <= 8'(r * 16 + b);
                end
            end
        end else if (wr_valid) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_data1 = regs[rd_idx1];
    assign rd_data2 = regs[rd_idx2];

    a_wr_idx_known: assert property (
        @(posedge clk) disable iff (!rst_n) wr_valid |-> !$isunknown(wr_idx)
    ) else $error("rvv_vrf: unknown write index");

endmodule

// ==== logic/rvv_valu.sv ====
`timescale 1ns/1ps
`include "rvv_settings.svh"

module rvv_valu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   uq_empty,
    output logic                   uq_pop,
    input  rvv_cmd_pkg::uop_t      uop,
    output logic [`VREG_IDX_W-1:0] rd_idx1,
    output logic [`VREG_IDX_W-1:0] rd_idx2,
    input  rvv_data_pkg::vreg_t    rd_data1,
    input  rvv_data_pkg::vreg_t    rd_data2,
    output logic                   wr_valid,
    output logic [`VREG_IDX_W-1:0] wr_idx,
    output rvv_data_pkg::vreg_t    wr_data,
    output logic                   rt_valid,
    output rvv_data_pkg::rt_rec_t  rt_rec
);
    import rvv_cmd_pkg::*;
    import rvv_data_pkg::*;

    vreg_t result;

    // Narrower elements use the low bits, so add and sub wrap at SEW
    function automatic logic [31:0] alu_elem(alu_op_e op, logic [31:0] a, logic [31:0] b);
        logic [31:0] r;
        case (op)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a - b;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            default: r = '0;
        endcase
        return r;
    endfunction

    assign uq_pop  = !uq_empty && !flush;
    assign rd_idx1 = uop.vs1;
    assign rd_idx2 = uop.vs2;

    // vd = vs2 op vs1
    always_comb begin
        result = '0;
        case (uop.sew)
            SEW8: begin
                for (int e = 0; e < `VLEN / 8; e++) begin
                    result[e*8 +: 8] = 8'(alu_elem(uop.alu_op,
                        32'(rd_data2[e*8 +: 8]), 32'(rd_data1[e*8 +: 8])));
                end
            end
            SEW16: begin
                for (int e = 0; e < `VLEN / 16; e++) begin
                    result[e*16 +: 16] = 16'(alu_elem(uop.alu_op,
                        32'(rd_data2[e*16 +: 16]), 32'(rd_data1[e*16 +: 16])));
                end
            end
            SEW32: begin
                for (int e = 0; e < `VLEN / 32; e++) begin
                    result[e*32 +: 32] = alu_elem(uop.alu_op,
                        rd_data2[e*32 +: 32], rd_data1[e*32 +: 32]);
                end
            end
            default: result = '0;
        endcase
    end

    // Write lands at the pop edge so the next micro-op sees it
    assign wr_valid = uq_pop && !uop.illegal;
    assign wr_idx   = uop.vd;
    assign wr_data  = result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rt_valid <= 1'b0;
        end else begin
            rt_valid <= uq_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (uq_pop) begin
            rt_rec.pc      <= uop.pc;
            rt_rec.vd      <= uop.vd;
            rt_rec.data    <= result;
            rt_rec.illegal <= uop.illegal;
        end
    end

    // Only a defined op at a supported SEW may reach the register file
    a_write_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_valid |-> (uop.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR})
            && (uop.sew inside {SEW8, SEW16, SEW32})
    ) else $error("rvv_valu: register write for an illegal micro-op");

endmodule

// ==== logic/rvv_decode.sv ====
`timescale 1ns/1ps

module rvv_decode (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rvv_cmd_pkg::rvv_cmd_t cmd,
    input  logic                  cq_empty,
    output logic                  cq_pop,
    input  logic                  uq_full,
    output logic                  uq_push,
    output rvv_cmd_pkg::uop_t     uop
);
    import rvv_cmd_pkg::*;

    localparam logic [6:0] OPC_OPV  = 7'b1010111;
    localparam logic [2:0] F3_OPIVV = 3'b000;

    logic [5:0] funct6;
    logic       is_opivv;
    logic       op_ok;
    alu_op_e    op;

    assign funct6   = cmd.inst[31:26];
    assign is_opivv = (cmd.inst[6:0] == OPC_OPV) && (cmd.inst[14:12] == F3_OPIVV);

    always_comb begin
        op    = ALU_ADD;
        op_ok = 1'b1;
        case (funct6)
            6'b000000: op = ALU_ADD;
            6'b000010: op = ALU_SUB;
            6'b001001: op = ALU_AND;
            6'b001010: op = ALU_OR;
            6'b001011: op = ALU_XOR;
            default:   op_ok = 1'b0;
        endcase
    end

    // Head moves on whenever the micro-op queue has room
    assign cq_pop  = !cq_empty && !uq_full;
    assign uq_push = cq_pop;

    always_comb begin
        uop.pc      = cmd.pc;
        uop.vs1     = cmd.inst[19:15];
        uop.vs2     = cmd.inst[24:20];
        uop.vd      = cmd.inst[11:7];
        uop.alu_op  = op;
        uop.sew     = cmd.sew;
        uop.illegal = !(is_opivv && op_ok && (cmd.sew inside {SEW8, SEW16, SEW32}));
    end

    // A popped head must be a command that was really pushed
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) cq_pop |-> !$isunknown(cmd)
    ) else $error("rvv_decode: pop of an unwritten command queue entry");

endmodule

// ==== logic/multi_fifo.sv ====
`timescale 1ns/1ps

module multi_fifo #(
    parameter type T     = logic [31:0],
    parameter int  M     = 1,
    parameter int  N     = 1,
    parameter int  DEPTH = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [M-1:0] push,
    input  T     [M-1:0] datain,
    input  logic [N-1:0] pop,
    output T     [N-1:0] dataout,
    output logic         full,
    output logic         almost_full,
    output logic         empty,
    output logic         almost_empty,
    input  logic         clear
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH) + 1;

    T mem [DEPTH];

    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] push_cnt;
    logic [CNT_W-1:0] pop_cnt;

    // Only the leading run of set bits counts
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < M; i++) begin
            if (push[i] && push_cnt == CNT_W'(i)) begin
                push_cnt = push_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        pop_cnt = '0;
        for (int i = 0; i < N; i++) begin
            if (pop[i] && pop_cnt == CNT_W'(i) && count > CNT_W'(i)) begin
                pop_cnt = pop_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            wptr  <= wptr + PTR_W'(push_cnt);
            rptr  <= rptr + PTR_W'(pop_cnt);
            count <= count + push_cnt - pop_cnt;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < M; i++) begin
            if (CNT_W'(i) < push_cnt) begin
                mem[wptr + PTR_W'(i)] <= datain[i];
            end
        end
    end

    always_comb begin
        for (int j = 0; j < N; j++) begin
            dataout[j] = mem[rptr + PTR_W'(j)];
        end
    end

    assign full         = (count == CNT_W'(DEPTH));
    assign empty        = (count == '0);
    // Fewer than M free slots
    assign almost_full  = (count > CNT_W'(DEPTH - M));
    assign almost_empty = (count < CNT_W'(N));

    a_push_contiguous: assert property (
        @(posedge clk) disable iff (!rst_n) ((push + 1'b1) & push) == '0
    ) else $error("multi_fifo: non-contiguous push %b", push);

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) full |-> !push[0]
    ) else $error("multi_fifo: push while full");

endmodule

// ==== logic/rvv_data_pkg.sv ====
`include "rvv_settings.svh"

package rvv_data_pkg;

    typedef logic [`VLEN-1:0] vreg_t;

    // One retired micro-op
    typedef struct packed {
        logic [31:0]            pc;
        logic [`VREG_IDX_W-1:0] vd;
        vreg_t                  data;
        logic                   illegal;
    } rt_rec_t;

endpackage

// ==== logic/rvv_cmd_pkg.sv ====
`include "rvv_settings.svh"

package rvv_cmd_pkg;

    // Element width of a command
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // Command as issued by the scalar core
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        sew_e        sew;
    } rvv_cmd_t;

    typedef struct packed {
        logic [31:0]            pc;
        logic [`VREG_IDX_W-1:0] vs1;
        logic [`VREG_IDX_W-1:0] vs2;
        logic [`VREG_IDX_W-1:0] vd;
        alu_op_e                alu_op;
        sew_e                   sew;
        logic                   illegal;
    } uop_t;

endpackage

// ==== include/rvv_settings.svh ====
`ifndef RVV_SETTINGS_SVH
`define RVV_SETTINGS_SVH

// Command lanes accepted per cycle
`define ISSUE_LANE 2

// Queue depths, powers of two
`define CQ_DEPTH 8
`define UQ_DEPTH 4

// Vector register file geometry
`define VLEN 128
`define NUM_VREG 32
`define VREG_IDX_W 5

`endif
